//--- rtl/mont_config.svh
`ifndef MONT_CONFIG_SVH
`define MONT_CONFIG_SVH

// Operand width N
`define MONT_WIDTH 1024

// Adder operand width, holds C + 3B + 3M which stays below 8m
`define MONT_OP_WIDTH (`MONT_WIDTH + 3)

// Bits added per cycle
`define MONT_ADDER_CHUNK 128

// Cycles per adder operation, rounded up
`define MONT_ADD_CYCLES ((`MONT_OP_WIDTH + `MONT_ADDER_CHUNK - 1) / `MONT_ADDER_CHUNK)

// Radix-4 iterations
`define MONT_ITERATIONS (`MONT_WIDTH / 2)
`define MONT_COUNT_WIDTH 10

`endif

//--- rtl/mont_pkg.sv
`include "mont_config.svh"

package mont_pkg;

    // One N-bit operand or result
    typedef logic [`MONT_WIDTH-1:0] word_t;

    // Adder operand and its sum with the carry or borrow on top
    typedef logic [`MONT_OP_WIDTH-1:0] operand_t;
    typedef logic [`MONT_OP_WIDTH:0]   sum_t;

    // Operations on the shared adder
    typedef enum logic [2:0] {
        OP_TRIPLE_B    = 3'd0,
        OP_TRIPLE_M    = 3'd1,
        OP_ADD_B_DIGIT = 3'd2,
        OP_ADD_M_DIGIT = 3'd3,
        OP_SUB_M       = 3'd4
    } mont_op_e;

    // Controller states
    typedef enum logic [2:0] {
        ST_IDLE   = 3'd0,
        ST_PRE_B  = 3'd1,
        ST_PRE_M  = 3'd2,
        ST_ITER_B = 3'd3,
        ST_ITER_M = 3'd4,
        ST_REDUCE = 3'd5,
        ST_DONE   = 3'd6
    } mont_state_e;

endpackage

//--- rtl/mp_adder.sv
`timescale 1ns/1ps
`include "mont_config.svh"

module mp_adder (
    input  logic               clk,
    input  logic               resetn,
    input  logic               start,
    input  logic               subtract,
    input  mont_pkg::operand_t in_a,
    input  mont_pkg::operand_t in_b,
    output mont_pkg::sum_t     result,
    output logic               done
);
    import mont_pkg::*;

    localparam int CHUNK   = `MONT_ADDER_CHUNK;
    localparam int PAD     = `MONT_ADD_CYCLES * CHUNK;
    localparam int SLICE_W = $clog2(`MONT_ADD_CYCLES + 1);

    logic [PAD-1:0]     a_q;
    logic [PAD-1:0]     b_q;
    logic [PAD-1:0]     sum_q;
    logic               carry_q;
    logic               sub_q;
    logic               busy_q;
    logic               done_q;
    logic [SLICE_W-1:0] slice_q;

    logic [PAD-1:0]     op_a;
    logic [PAD-1:0]     op_b;
    logic               cin;
    logic [CHUNK:0]     slice_sum;

    // First slice is added in the start cycle straight from the inputs
    assign op_a = start ? {{(PAD-`MONT_OP_WIDTH){1'b0}}, in_a} : a_q;
    assign op_b = start ? {{(PAD-`MONT_OP_WIDTH){1'b0}}, subtract ? ~in_b : in_b} : b_q;
    assign cin  = start ? subtract : carry_q;

    assign slice_sum = {1'b0, op_a[CHUNK-1:0]} + {1'b0, op_b[CHUNK-1:0]} + {{CHUNK{1'b0}}, cin};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy_q  <= 1'b0;
            done_q  <= 1'b0;
            slice_q <= '0;
        end else begin
            done_q <= 1'b0;
            if (start) begin
                busy_q  <= 1'b1;
                slice_q <= SLICE_W'(1);
            end else if (busy_q) begin
                slice_q <= slice_q + 1'b1;
                if (slice_q == SLICE_W'(`MONT_ADD_CYCLES - 1)) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    // Operands shift down one chunk per slice, sum fills in from the top
    always_ff @(posedge clk) begin
        if (start || busy_q) begin
            a_q     <= op_a >> CHUNK;
            b_q     <= op_b >> CHUNK;
            carry_q <= slice_sum[CHUNK];
            sum_q   <= {slice_sum[CHUNK-1:0], sum_q[PAD-1:CHUNK]};
        end
        if (start) begin
            sub_q <= subtract;
        end
    end

    // Top bit is the carry for an add and the borrow for a subtract
    assign result = sum_t'({sum_q[`MONT_OP_WIDTH] ^ sub_q, sum_q[`MONT_OP_WIDTH-1:0]});
    assign done   = done_q;

    a_no_start_busy: assert property (@(posedge clk) disable iff (!resetn)
        start |-> !busy_q)
        else $error("mp_adder: start while an operation is in flight");

endmodule

//--- rtl/multiple_select.sv
`timescale 1ns/1ps

module multiple_select (
    input  logic [1:0]         a_digit,
    input  logic [1:0]         acc_low,
    input  logic [1:0]         m_low,
    input  mont_pkg::operand_t b,
    input  mont_pkg::operand_t b2,
    input  mont_pkg::operand_t b3,
    input  mont_pkg::operand_t m,
    input  mont_pkg::operand_t m2,
    input  mont_pkg::operand_t m3,
    input  logic               use_m,
    output mont_pkg::operand_t multiple
);
    import mont_pkg::*;

    logic [1:0] prod_low;
    logic [1:0] q_digit;
    operand_t   b_pick;
    operand_t   m_pick;

    // m is its own inverse mod 4, so q = -C * m mod 4
    assign prod_low = acc_low * m_low;
    assign q_digit  = ~prod_low + 2'd1;

    always_comb begin
        case (a_digit)
            2'd0:    b_pick = '0;
            2'd1:    b_pick = b;
            2'd2:    b_pick = b2;
            default: b_pick = b3;
        endcase
    end

    always_comb begin
        case (q_digit)
            2'd0:    m_pick = '0;
            2'd1:    m_pick = m;
            2'd2:    m_pick = m2;
            default: m_pick = m3;
        endcase
    end

    assign multiple = use_m ? m_pick : b_pick;

endmodule

//--- rtl/mont_datapath.sv
`timescale 1ns/1ps
`include "mont_config.svh"

module mont_datapath (
    input  logic                clk,
    input  logic                resetn,
    input  logic                load,
    input  logic                shift,
    input  logic                finish,
    input  mont_pkg::mont_op_e  op,
    input  mont_pkg::word_t     in_a,
    input  mont_pkg::word_t     in_b,
    input  mont_pkg::word_t     in_m,
    input  mont_pkg::sum_t      add_sum,
    input  logic                add_done,
    output mont_pkg::operand_t  add_a,
    output mont_pkg::operand_t  add_b,
    output logic                subtract,
    output mont_pkg::word_t     result
);
    import mont_pkg::*;

    localparam int EXT = `MONT_OP_WIDTH - `MONT_WIDTH;

    word_t    a_q;
    word_t    b_q;
    word_t    m_q;
    operand_t b3_q;
    operand_t m3_q;
    operand_t acc_q;
    word_t    result_q;

    operand_t b_ext;
    operand_t b2;
    operand_t m_ext;
    operand_t m2;
    operand_t multiple;
    logic     borrow;

    assign b_ext = {{EXT{1'b0}}, b_q};
    assign m_ext = {{EXT{1'b0}}, m_q};
    assign b2    = {{(EXT-1){1'b0}}, b_q, 1'b0};
    assign m2    = {{(EXT-1){1'b0}}, m_q, 1'b0};

    multiple_select u_multiple_select (
        .a_digit  (a_q[1:0]),
        .acc_low  (acc_q[1:0]),
        .m_low    (m_q[1:0]),
        .b        (b_ext),
        .b2       (b2),
        .b3       (b3_q),
        .m        (m_ext),
        .m2       (m2),
        .m3       (m3_q),
        .use_m    (op == OP_ADD_M_DIGIT),
        .multiple (multiple)
    );

    // Adder operand decode
    always_comb begin
        subtract = 1'b0;
        case (op)
            OP_TRIPLE_B: begin
                add_a = b2;
                add_b = b_ext;
            end
            OP_TRIPLE_M: begin
                add_a = m2;
                add_b = m_ext;
            end
            OP_SUB_M: begin
                add_a    = acc_q;
                add_b    = m_ext;
                subtract = 1'b1;
            end
            default: begin
                add_a = acc_q;
                add_b = multiple;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (load) begin
            a_q   <= in_a;
            b_q   <= in_b;
            m_q   <= in_m;
            acc_q <= '0;
        end else if (add_done) begin
            case (op)
                OP_TRIPLE_B:    b3_q  <= add_sum[`MONT_OP_WIDTH-1:0];
                OP_TRIPLE_M:    m3_q  <= add_sum[`MONT_OP_WIDTH-1:0];
                OP_ADD_B_DIGIT: acc_q <= add_sum[`MONT_OP_WIDTH-1:0];
                // Low two bits are zero after the M pass
                OP_ADD_M_DIGIT: acc_q <= {2'b00, add_sum[`MONT_OP_WIDTH-1:2]};
                default: ;
            endcase
            if (shift) begin
                a_q <= {2'b00, a_q[`MONT_WIDTH-1:2]};
            end
        end
    end

    // Accumulator is below 2m, one subtraction brings it below m
    assign borrow = add_sum[`MONT_OP_WIDTH];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            result_q <= '0;
        end else if (finish) begin
            result_q <= borrow ? acc_q[`MONT_WIDTH-1:0] : add_sum[`MONT_WIDTH-1:0];
        end
    end

    assign result = result_q;

endmodule

//--- rtl/mont_controller.sv
`timescale 1ns/1ps
`include "mont_config.svh"

module mont_controller (
    input  logic               clk,
    input  logic               resetn,
    input  logic               start,
    input  logic               add_done,
    output logic               add_start,
    output logic               load,
    output logic               shift,
    output logic               finish,
    output logic               done,
    output mont_pkg::mont_op_e op
);
    import mont_pkg::*;

    mont_state_e                 state_q;
    mont_state_e                 state_d;
    logic                        issued_q;
    logic [`MONT_COUNT_WIDTH-1:0] iter_q;
    logic                        last_iter;
    logic                        in_op_state;

    assign last_iter   = (iter_q == `MONT_COUNT_WIDTH'(`MONT_ITERATIONS - 1));
    assign in_op_state = state_q inside {ST_PRE_B, ST_PRE_M, ST_ITER_B, ST_ITER_M, ST_REDUCE};

    // One adder operation per state, issued in its first cycle
    assign add_start = in_op_state && !issued_q;
    assign load      = (state_q == ST_IDLE) && start;
    assign shift     = (state_q == ST_ITER_M) && add_done;
    assign finish    = (state_q == ST_REDUCE) && add_done;
    assign done      = (state_q == ST_DONE);

    always_comb begin
        case (state_q)
            ST_PRE_M:  op = OP_TRIPLE_M;
            ST_ITER_B: op = OP_ADD_B_DIGIT;
            ST_ITER_M: op = OP_ADD_M_DIGIT;
            ST_REDUCE: op = OP_SUB_M;
            default:   op = OP_TRIPLE_B;
        endcase
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (start) begin
                    state_d = ST_PRE_B;
                end
            end
            ST_PRE_B: begin
                if (add_done) begin
                    state_d = ST_PRE_M;
                end
            end
            ST_PRE_M: begin
                if (add_done) begin
                    state_d = ST_ITER_B;
                end
            end
            ST_ITER_B: begin
                if (add_done) begin
                    state_d = ST_ITER_M;
                end
            end
            ST_ITER_M: begin
                if (add_done) begin
                    state_d = last_iter ? ST_REDUCE : ST_ITER_B;
                end
            end
            ST_REDUCE: begin
                if (add_done) begin
                    state_d = ST_DONE;
                end
            end
            ST_DONE: state_d = ST_IDLE;
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q  <= ST_IDLE;
            issued_q <= 1'b0;
            iter_q   <= '0;
        end else begin
            state_q <= state_d;
            if (add_done) begin
                issued_q <= 1'b0;
            end else if (add_start) begin
                issued_q <= 1'b1;
            end
            // Counts finished iterations, one per M pass
            if (load) begin
                iter_q <= '0;
            end else if (shift) begin
                iter_q <= iter_q + 1'b1;
            end
        end
    end

    // Adder results only come back for an operation issued here
    a_done_issued: assert property (@(posedge clk) disable iff (!resetn)
        add_done |-> issued_q)
        else $error("mont_controller: add_done without an issued operation");

    // Host must not start a new run while one is in progress
    a_start_idle: assert property (@(posedge clk) disable iff (!resetn)
        start |-> state_q == ST_IDLE)
        else $error("mont_controller: start while busy is ignored");

endmodule

//--- rtl/montgomery_top.sv
`timescale 1ns/1ps

module montgomery_top (
    input  logic            clk,
    input  logic            resetn,
    input  logic            start,
    input  mont_pkg::word_t in_a,
    input  mont_pkg::word_t in_b,
    input  mont_pkg::word_t in_m,
    output mont_pkg::word_t result,
    output logic            done
);
    import mont_pkg::*;

    mont_op_e op;
    logic     load;
    logic     shift;
    logic     finish;
    logic     add_start;
    logic     add_done;
    logic     subtract;
    operand_t add_a;
    operand_t add_b;
    sum_t     add_sum;

    mont_controller u_controller (
        .clk       (clk),
        .resetn    (resetn),
        .start     (start),
        .add_done  (add_done),
        .add_start (add_start),
        .load      (load),
        .shift     (shift),
        .finish    (finish),
        .done      (done),
        .op        (op)
    );

    mont_datapath u_datapath (
        .clk      (clk),
        .resetn   (resetn),
        .load     (load),
        .shift    (shift),
        .finish   (finish),
        .op       (op),
        .in_a     (in_a),
        .in_b     (in_b),
        .in_m     (in_m),
        .add_sum  (add_sum),
        .add_done (add_done),
        .add_a    (add_a),
        .add_b    (add_b),
        .subtract (subtract),
        .result   (result)
    );

    // Shared adder for every step of the run
    mp_adder u_adder (
        .clk      (clk),
        .resetn   (resetn),
        .start    (add_start),
        .subtract (subtract),
        .in_a     (add_a),
        .in_b     (add_b),
        .result   (add_sum),
        .done     (add_done)
    );

endmodule

//--- verification/mont_ref_model.svh
`ifndef MONT_REF_MODEL_SVH
`define MONT_REF_MODEL_SVH

// Bit-serial Montgomery product a*b*2^-N mod m, for odd m with a and b below m
function automatic logic [`MONT_WIDTH-1:0] montgomery_product(
    input logic [`MONT_WIDTH-1:0] a,
    input logic [`MONT_WIDTH-1:0] b,
    input logic [`MONT_WIDTH-1:0] m
);
    // Two spare bits, the sum stays below 4m inside the loop
    logic [`MONT_WIDTH+1:0] s;
    int                     i;
    s = '0;
    for (i = 0; i < `MONT_WIDTH; i++) begin
        if (a[i]) begin
            s = s + b;
        end
        // Adding m clears the low bit so the halving is exact
        if (s[0]) begin
            s = s + m;
        end
        s = s >> 1;
    end
    // Below 2m here, one subtraction is enough
    if (s >= m) begin
        s = s - m;
    end
    return s[`MONT_WIDTH-1:0];
endfunction

`endif

//--- verification/montgomery_tb.sv
`timescale 1ns/1ps
`include "mont_config.svh"

module montgomery_tb;
    import mont_pkg::*;

    `include "mont_ref_model.svh"

    localparam int    TIMEOUT_CYCLES = 20000;
    localparam int    RUN_CYCLES     = (3 + `MONT_WIDTH) * (`MONT_ADD_CYCLES + 1);
    localparam word_t FIXED_M        = {32{32'hf3a5c96b}};

    logic   clk;
    logic   resetn;
    logic   start;
    word_t  in_a;
    word_t  in_b;
    word_t  in_m;
    word_t  result;
    logic   done;
    int     errors;
    int     checks;
    integer seed;

    montgomery_top uut (
        .clk    (clk),
        .resetn (resetn),
        .start  (start),
        .in_a   (in_a),
        .in_b   (in_b),
        .in_m   (in_m),
        .result (result),
        .done   (done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic end_simulation;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    task automatic compare_result(input word_t expected);
        checks++;
        if (result !== expected) begin
            errors++;
            $display("CHECK FAILED: result = %h, expected %h", result, expected);
        end
    endtask

    task automatic expect_done_low;
        checks++;
        if (done !== 1'b0) begin
            errors++;
            $display("CHECK FAILED: done = %h, expected %h", done, 1'b0);
        end
    endtask

    task automatic random_word(output word_t w);
        int i;
        for (i = 0; i < `MONT_WIDTH / 32; i++) begin
            w[i*32 +: 32] = $random(seed);
        end
    endtask

    // Odd modulus with its top bit set, operands reduced below it
    task automatic random_operands(output word_t a, output word_t b, output word_t m);
        random_word(m);
        m[`MONT_WIDTH-1] = 1'b1;
        m[0] = 1'b1;
        random_word(a);
        a = a % m;
        random_word(b);
        b = b % m;
    endtask

    task automatic issue_start(input word_t a, input word_t b, input word_t m);
        @(posedge clk);
        in_a  <= a;
        in_b  <= b;
        in_m  <= m;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_done;
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (done !== 1'b1 && cycles < TIMEOUT_CYCLES);
        if (done !== 1'b1) begin
            errors++;
            $display("Timeout: done did not rise within %0d cycles", TIMEOUT_CYCLES);
        end
    endtask

    // One full run, then done must drop after a single cycle
    task automatic run_and_check(input word_t a, input word_t b, input word_t m);
        word_t expected;
        expected = montgomery_product(a, b, m);
        issue_start(a, b, m);
        wait_done();
        compare_result(expected);
        @(negedge clk);
        expect_done_low();
    endtask

    task automatic test_idle_after_reset;
        repeat (20) begin
            @(negedge clk);
            expect_done_low();
        end
    endtask

    task automatic test_unit_and_zero;
        word_t b;
        run_and_check(word_t'(1), word_t'(1), FIXED_M);
        b = FIXED_M >> 3;
        run_and_check('0, b, FIXED_M);
        compare_result('0);
    endtask

    task automatic test_random_sets;
        word_t a;
        word_t b;
        word_t m;
        repeat (8) begin
            random_operands(a, b, m);
            run_and_check(a, b, m);
        end
    endtask

    // Next start goes out in the cycle after done
    task automatic test_back_to_back;
        word_t a[3];
        word_t b[3];
        word_t m[3];
        word_t expected;
        int    k;
        for (k = 0; k < 3; k++) begin
            random_operands(a[k], b[k], m[k]);
        end
        issue_start(a[0], b[0], m[0]);
        for (k = 0; k < 3; k++) begin
            expected = montgomery_product(a[k], b[k], m[k]);
            wait_done();
            compare_result(expected);
            @(posedge clk);
            if (k < 2) begin
                in_a  <= a[k+1];
                in_b  <= b[k+1];
                in_m  <= m[k+1];
                start <= 1'b1;
            end
            @(negedge clk);
            expect_done_low();
            compare_result(expected);
            @(posedge clk);
            start <= 1'b0;
            // Old result stays while the next run is busy
            repeat (20) @(negedge clk);
            compare_result(expected);
        end
    endtask

    task automatic test_reset_mid_run;
        word_t a;
        word_t b;
        word_t m;
        random_operands(a, b, m);
        issue_start(a, b, m);
        repeat (500) @(negedge clk);
        @(posedge clk);
        resetn <= 1'b0;
        repeat (3) @(posedge clk);
        resetn <= 1'b1;
        // Past the point where the aborted run would have finished
        repeat (RUN_CYCLES) begin
            @(negedge clk);
            expect_done_low();
        end
        random_operands(a, b, m);
        run_and_check(a, b, m);
    endtask

    initial begin
        resetn = 1'b0;
        start  = 1'b0;
        in_a   = '0;
        in_b   = '0;
        in_m   = '0;
        errors = 0;
        checks = 0;
        seed   = 39;
        repeat (3) @(posedge clk);
        resetn <= 1'b1;
        test_idle_after_reset();
        test_unit_and_zero();
        test_random_sets();
        test_back_to_back();
        test_reset_mid_run();
        end_simulation();
    end

endmodule

//--- montgomery.f
+incdir+rtl
+incdir+verification
rtl/mont_pkg.sv
rtl/mp_adder.sv
rtl/multiple_select.sv
rtl/mont_datapath.sv
rtl/mont_controller.sv
rtl/montgomery_top.sv
verification/montgomery_tb.sv

//--- Bender.yml
package:
  name: montgomery

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mont_pkg.sv
      - rtl/mp_adder.sv
      - rtl/multiple_select.sv
      - rtl/mont_datapath.sv
      - rtl/mont_controller.sv
      - rtl/montgomery_top.sv
  - target: simulation
    include_dirs:
      - rtl
      - verification
    files:
      - verification/montgomery_tb.sv
